// File: ras_predictor.f
+incdir+design
design/ras_pkg.sv
design/branch_classifier.sv
design/checkpoint_fifo.sv
design/return_stack.sv
design/ras_predictor.sv
sim/tb_ras_predictor.sv

// File: sim/tb_ras_predictor.sv
`timescale 1ns/1ps
`include "ras_macros.svh"

module tb_ras_predictor;

    import ras_pkg::*;

    ////////////////////
    // Constants.

    localparam int DEPTH   = `RAS_DEPTH;
    localparam int MAX_IDS = `RAS_MAX_IDS;
    localparam int WAIT_MAX = 50; // Cycles any wait may take.

    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;

    ////////////////////
    // DUT signals.

    logic       clk;
    logic       arst_n;
    logic       fetch_valid;
    addr_t      fetch_pc;
    logic [31:0] fetch_instr;
    logic       fetch_flush;
    logic       branch_retired;
    xfer_kind_t xfer_kind;
    addr_t      predicted_target;
    credit_t    credit_return;

    // Reference model state.
    addr_t model_ram [DEPTH];     // Link addresses as the stack should hold them.
    bit    model_written [DEPTH]; // Slot has been pushed at least once.
    int    model_ptr;             // Stack pointer, modulo DEPTH.
    int    ckpt_q [$];            // Saved pointers, oldest first.
    int    credits;               // Credits the fetch side holds.
    int    exp_credit;            // credit_return expected next cycle.

    ras_predictor u_dut (
        .clk              (clk),
        .arst_n           (arst_n),
        .fetch_valid      (fetch_valid),
        .fetch_pc         (fetch_pc),
        .fetch_instr      (fetch_instr),
        .fetch_flush      (fetch_flush),
        .branch_retired   (branch_retired),
        .xfer_kind        (xfer_kind),
        .predicted_target (predicted_target),
        .credit_return    (credit_return)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period.
    end

    ////////////////////
    // Failure reporting and compares.

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "Simulation stopped at first error.");
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_kind(input string name, input xfer_kind_t got, input xfer_kind_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_credit(input string name, input credit_t got, input credit_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    ////////////////////
    // Encoders and expected decode.

    function automatic logic [31:0] enc_jal(input logic [4:0] rd);
        return {20'h00010, rd, OPC_JAL}; // Offset does not matter here.
    endfunction

    function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
        return {12'h000, rs1, 3'b000, rd, OPC_JALR};
    endfunction

    function automatic logic [31:0] enc_branch(input logic [2:0] f3);
        return {7'h00, 5'd2, 5'd3, f3, 5'h08, OPC_BRANCH}; // Compares x3 and x2.
    endfunction

    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1);
        return {12'h001, rs1, 3'b000, rd, OPC_OPIMM};
    endfunction

    // Expected kind by the link-register rules. x1 and x5 link.
    function automatic xfer_kind_t expect_kind(input logic [31:0] instr);
        logic [4:0] rd;
        logic [4:0] rs1;
        logic       rd_l;
        logic       rs1_l;
        rd    = instr[11:7];
        rs1   = instr[19:15];
        rd_l  = (rd == 5'd1) || (rd == 5'd5);
        rs1_l = (rs1 == 5'd1) || (rs1 == 5'd5);
        case (instr[6:0])
            OPC_JAL:    return rd_l ? XFER_CALL : XFER_NONE;
            OPC_BRANCH: return XFER_BRANCH;
            OPC_JALR: begin
                if (rd_l && rs1_l && (rd != rs1)) return XFER_CORO;
                else if (rd_l) return XFER_CALL;
                else if (rs1_l) return XFER_RETURN;
                else return XFER_NONE; // Plain indirect jump.
            end
            default:    return XFER_NONE;
        endcase
    endfunction

    function automatic addr_t rand_pc();
        return addr_t'($urandom() & 32'hFFFF_FFFC); // Word aligned.
    endfunction

    ////////////////////
    // Cycle driver with model update.

    task automatic step(input logic v, input addr_t pc, input logic [31:0] instr,
                        input logic fl, input logic rt);
        xfer_kind_t k;
        logic       do_push;
        logic       do_pop;
        logic       do_ckpt;
        @(negedge clk);
        // Credit is zero unless the last cycle retired or flushed.
        check_credit("credit_return", credit_return, credit_t'(exp_credit));
        credits += int'(credit_return);
        if (credits > MAX_IDS) begin
            abort_run("More credits came back than were ever granted.");
        end
        fetch_valid    = v;
        fetch_pc       = pc;
        fetch_instr    = instr;
        fetch_flush    = fl;
        branch_retired = rt;
        #1;
        k = (v && !fl) ? expect_kind(instr) : XFER_NONE; // Fetch ignored on flush.
        check_kind("xfer_kind", xfer_kind, k);
        if ((k == XFER_RETURN || k == XFER_CORO) && model_written[model_ptr]) begin
            check_addr("predicted_target", predicted_target, model_ram[model_ptr]);
        end
        do_push = (k == XFER_CALL) || (k == XFER_CORO);
        do_pop  = (k == XFER_RETURN) || (k == XFER_CORO);
        do_ckpt = v && !fl && (instr[6:0] == OPC_JALR || instr[6:0] == OPC_BRANCH);
        if (fl) begin
            exp_credit = ckpt_q.size(); // Every checkpoint is discarded.
            if (ckpt_q.size() != 0) model_ptr = ckpt_q[0];
            ckpt_q.delete();
        end else begin
            exp_credit = (rt && ckpt_q.size() != 0) ? 1 : 0;
            if (rt && ckpt_q.size() != 0) void'(ckpt_q.pop_front());
            if (do_ckpt) begin
                if (credits == 0) begin
                    abort_run("Checkpoint sent with no credit left.");
                end
                credits--;
                ckpt_q.push_back(model_ptr); // Pointer before this push or pop.
            end
            model_ptr = (model_ptr + int'(do_push) - int'(do_pop) + DEPTH) % DEPTH;
            if (do_push) begin
                model_ram[model_ptr]     = addr_t'(pc + 32'd4);
                model_written[model_ptr] = 1'b1;
            end
        end
    endtask

    // Idles, retiring where possible, until enough credits are back.
    task automatic wait_credits(input int need);
        int t;
        t = 0;
        while (credits < need) begin
            if (t == WAIT_MAX) begin
                abort_run("Timed out waiting for credits to come back.");
            end
            step(1'b0, '0, '0, 1'b0, ckpt_q.size() != 0);
            t++;
        end
    endtask

    task automatic fetch(input addr_t pc, input logic [31:0] instr);
        if (instr[6:0] == OPC_JALR || instr[6:0] == OPC_BRANCH) wait_credits(1);
        step(1'b1, pc, instr, 1'b0, 1'b0);
    endtask

    task automatic retire_one();
        step(1'b0, '0, '0, 1'b0, 1'b1);
    endtask

    // Retire everything in flight and collect all credits.
    task automatic drain();
        wait_credits(MAX_IDS);
        step(1'b0, '0, '0, 1'b0, 1'b0); // Settle the last credit_return.
    endtask

    // A call is fetched in the flush cycle and must be ignored.
    task automatic flush_pulse(input logic rt);
        step(1'b1, rand_pc(), enc_jal(5'd1), 1'b1, rt);
    endtask

    ////////////////////
    // Directed tests.

    task automatic test_classify();
        logic [4:0] regs [4];
        regs[0] = 5'd0;
        regs[1] = 5'd1;
        regs[2] = 5'd5;
        regs[3] = 5'd6;
        for (int i = 0; i < 4; i++) begin
            fetch(rand_pc(), enc_jal(regs[i]));
            for (int j = 0; j < 4; j++) begin
                fetch(rand_pc(), enc_jalr(regs[i], regs[j])); // Every rd, rs1 pair.
                fetch(rand_pc(), enc_addi(regs[i], regs[j]));
            end
        end
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) fetch(rand_pc(), enc_branch(3'(f)));
        end
        step(1'b0, rand_pc(), enc_jal(5'd1), 1'b0, 1'b0); // Invalid slot is NONE.
        drain();
    endtask

    task automatic test_nesting();
        addr_t links [$];
        addr_t pc;
        int    depth;
        for (int r = 0; r < 6; r++) begin
            depth = $urandom_range(1, DEPTH);
            repeat (depth) begin
                pc = rand_pc();
                fetch(pc, enc_jal(5'd1));
                links.push_back(addr_t'(pc + 32'd4));
            end
            if (r % 2 == 1) begin
                pc = rand_pc();
                fetch(pc, enc_jalr(5'd5, 5'd1)); // Coroutine swap.
                check_addr("predicted_target", predicted_target, links[$]);
                links[$] = addr_t'(pc + 32'd4);
            end
            while (links.size() != 0) begin
                fetch(rand_pc(), enc_jalr(5'd0, (r % 2 == 1) ? 5'd5 : 5'd1));
                check_addr("predicted_target", predicted_target, links.pop_back());
            end
        end
        drain();
    endtask

    task automatic test_overflow();
        addr_t links [$];
        addr_t pc;
        repeat (DEPTH + 3) begin
            pc = rand_pc();
            fetch(pc, enc_jal(5'd1));
            links.push_back(addr_t'(pc + 32'd4));
        end
        // Only the newest DEPTH entries survive the wrap.
        for (int i = 0; i < DEPTH; i++) begin
            fetch(rand_pc(), enc_jalr(5'd0, 5'd1));
            check_addr("predicted_target", predicted_target, links[links.size() - 1 - i]);
        end
        drain();
    endtask

    task automatic test_flush_restore();
        addr_t pc;
        addr_t link_a;
        addr_t link_b;
        pc = rand_pc();
        fetch(pc, enc_jal(5'd1));
        link_a = addr_t'(pc + 32'd4);
        fetch(rand_pc(), enc_branch(3'b000));  // Oldest checkpoint.
        pc = rand_pc();
        fetch(pc, enc_jal(5'd1));
        link_b = addr_t'(pc + 32'd4);
        fetch(rand_pc(), enc_branch(3'b001));  // Saves the pointer at B.
        fetch(rand_pc(), enc_jal(5'd1));
        fetch(rand_pc(), enc_jal(5'd5));
        retire_one();                          // First branch retires.
        flush_pulse(1'b0);
        fetch(rand_pc(), enc_jalr(5'd0, 5'd1));
        check_addr("predicted_target", predicted_target, link_b);
        fetch(rand_pc(), enc_jalr(5'd0, 5'd1));
        check_addr("predicted_target", predicted_target, link_a);
        drain();
        // No retire before the flush this time.
        pc = rand_pc();
        fetch(pc, enc_jal(5'd1));
        link_a = addr_t'(pc + 32'd4);
        fetch(rand_pc(), enc_jalr(5'd0, 5'd6));  // Indirect jump checkpoints too.
        fetch(rand_pc(), enc_jal(5'd1));
        flush_pulse(1'b0);
        fetch(rand_pc(), enc_jalr(5'd0, 5'd1));
        check_addr("predicted_target", predicted_target, link_a);
        drain();
        // A flush with no branch in flight keeps the pointer.
        pc = rand_pc();
        fetch(pc, enc_jal(5'd1));
        link_a = addr_t'(pc + 32'd4);
        flush_pulse(1'b0);
        fetch(rand_pc(), enc_jalr(5'd0, 5'd1));
        check_addr("predicted_target", predicted_target, link_a);
        drain();
    endtask

    task automatic test_credits();
        repeat (MAX_IDS) fetch(rand_pc(), enc_branch(3'b100));
        check_credit("fetch_credits", credit_t'(credits), credit_t'(0));
        retire_one();
        retire_one();
        step(1'b0, '0, '0, 1'b0, 1'b0);
        check_credit("fetch_credits", credit_t'(credits), credit_t'(2));
        flush_pulse(1'b1); // Retire in the flush cycle counts as discarded.
        step(1'b0, '0, '0, 1'b0, 1'b0);
        check_credit("fetch_credits", credit_t'(credits), credit_t'(MAX_IDS));
        drain();
    endtask

    ////////////////////
    // Main sequence.

    initial begin
        void'($urandom(21041));
        fetch_valid    = 1'b0;
        fetch_pc       = '0;
        fetch_instr    = '0;
        fetch_flush    = 1'b0;
        branch_retired = 1'b0;
        arst_n         = 1'b0;
        model_ptr      = 0;
        credits        = MAX_IDS; // Granted at reset.
        exp_credit     = 0;
        foreach (model_written[i]) model_written[i] = 1'b0;
        repeat (16) @(posedge clk);
        check_credit("credit_return", credit_return, credit_t'(0));
        @(negedge clk);
        arst_n = 1'b1;

        test_classify();
        test_nesting();
        test_overflow();
        test_flush_restore();
        test_credits();

        $display("test passed");
        $finish;
    end

endmodule

// File: design/ras_predictor.sv
`timescale 1ns/1ps

module ras_predictor (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                fetch_valid,
    input  ras_pkg::addr_t      fetch_pc,
    input  logic [31:0]         fetch_instr,
    input  logic                fetch_flush,
    input  logic                branch_retired,
    output ras_pkg::xfer_kind_t xfer_kind,
    output ras_pkg::addr_t      predicted_target,
    output ras_pkg::credit_t    credit_return
);

    import ras_pkg::*;

    ////////////////////
    // Internal nets.

    logic       push;          // Call or coroutine.
    logic       pop;           // Return or coroutine.
    logic       checkpoint;    // Mispredictable transfer fetched.
    addr_t      link_addr;     // PC plus four.
    ras_index_t read_index;    // Current stack pointer.
    logic       restore_valid; // A branch is in flight.
    ras_index_t restore_index; // Pointer saved by the oldest branch.

    ////////////////////
    // Decode.

    // Fetch in a flush cycle is wrong-path, so it is masked here.
    branch_classifier u_classifier (
        .fetch_valid (fetch_valid & ~fetch_flush),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr),
        .kind        (xfer_kind),
        .push        (push),
        .pop         (pop),
        .checkpoint  (checkpoint),
        .link_addr   (link_addr)
    );

    ////////////////////
    // Stack and checkpoints.

    return_stack u_stack (
        .clk           (clk),
        .arst_n        (arst_n),
        .flush         (fetch_flush),
        .push          (push),
        .pop           (pop),
        .new_addr      (link_addr),
        .restore_valid (restore_valid),
        .restore_index (restore_index),
        .top_addr      (predicted_target), // Same-cycle prediction.
        .read_index    (read_index)
    );

    // Each checkpoint saves the pointer from before its own push or pop.
    checkpoint_fifo #(
        .payload_t (ras_index_t)
    ) u_ckpt_fifo (
        .clk           (clk),
        .arst_n        (arst_n),
        .flush         (fetch_flush),
        .push          (checkpoint),
        .data_in       (read_index),
        .pop           (branch_retired),
        .valid         (restore_valid),
        .data_out      (restore_index),
        .credit_return (credit_return)
    );

endmodule

// File: design/return_stack.sv
`timescale 1ns/1ps
`include "ras_macros.svh"

module return_stack (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                flush,
    input  logic                push,
    input  logic                pop,
    input  ras_pkg::addr_t      new_addr,
    input  logic                restore_valid,
    input  ras_pkg::ras_index_t restore_index,
    output ras_pkg::addr_t      top_addr,
    output ras_pkg::ras_index_t read_index
);

    import ras_pkg::*;

    ////////////////////
    // Storage.

    // Small enough to map onto distributed LUT RAM.
    addr_t stack_ram [`RAS_DEPTH];

    ras_index_t base_index; // Pointer the update starts from.
    ras_index_t next_index; // Pointer after this cycle's push and pop.

    // Asynchronous read at the current top.
    // The value seen here is from before any push in this cycle.
    assign top_addr = stack_ram[read_index];

    ////////////////////
    // Pointer arithmetic.

    // A flush rewinds to the pointer saved by the oldest open branch.
    // With no branch in flight the current pointer is already correct.
    assign base_index = (flush && restore_valid) ? restore_index : read_index;

    // Index width is log2 of the depth, so overflow wraps modulo depth
    // and the oldest entries get overwritten.
    // A coroutine pops and pushes, so the pointer stays and the top is replaced.
    assign next_index = base_index
                      + ras_index_t'(push)
                      - ras_index_t'(pop);

    ////////////////////
    // RAM write.

    always_ff @(posedge clk) begin
        if (push) begin
            stack_ram[next_index] <= new_addr; // Link address lands on new top.
        end
    end

    ////////////////////
    // Pointer register.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            read_index <= '0; // Empty stack points at slot zero.
        end else begin
            read_index <= next_index; // Visible from the next cycle.
        end
    end

endmodule

// File: design/checkpoint_fifo.sv
`timescale 1ns/1ps
`include "ras_macros.svh"

module checkpoint_fifo #(
    parameter type payload_t = ras_pkg::ras_index_t
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             flush,
    input  logic             push,
    input  payload_t         data_in,
    input  logic             pop,
    output logic             valid,
    output payload_t         data_out,
    output ras_pkg::credit_t credit_return
);

    import ras_pkg::*;

    ////////////////////
    // Geometry.

    localparam int DEPTH = `RAS_MAX_IDS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef logic [PTR_W-1:0] ptr_t;

    // Circular increment that also works for depths other than powers of two.
    function automatic ptr_t next_ptr(input ptr_t p);
        return (p == ptr_t'(DEPTH - 1)) ? '0 : p + ptr_t'(1);
    endfunction

    payload_t mem [DEPTH]; // Checkpoint storage.

    ptr_t    wr_ptr;    // Next free slot.
    ptr_t    rd_ptr;    // Oldest entry.
    credit_t count;     // Occupancy, 0 to DEPTH.
    logic    full;
    logic    push_ok;
    logic    pop_ok;

    assign full  = (count == credit_t'(DEPTH));
    assign valid = (count != '0);

    assign push_ok = push && !full && !flush; // A push made while full is dropped.
    assign pop_ok  = pop && valid;            // A retire with nothing in flight is ignored.

    assign data_out = mem[rd_ptr]; // Oldest checkpoint is read combinationally.

    ////////////////////
    // Storage write.

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= data_in;
        end
    end

    ////////////////////
    // Pointers, occupancy and credits.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= '0;
        end else if (flush) begin
            wr_ptr        <= '0; // Discard every checkpoint.
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= count; // Includes a retire in the same cycle.
        end else begin
            if (push_ok) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_ok) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous push and pop leave the count unchanged.
            count         <= count + credit_t'(push_ok) - credit_t'(pop_ok);
            credit_return <= credit_t'(pop_ok); // One credit per retire.
        end
    end

endmodule

// File: design/branch_classifier.sv
`timescale 1ns/1ps

module branch_classifier (
    input  logic                   fetch_valid,
    input  ras_pkg::addr_t         fetch_pc,
    input  logic [31:0]            fetch_instr,
    output ras_pkg::xfer_kind_t    kind,
    output logic                   push,
    output logic                   pop,
    output logic                   checkpoint,
    output ras_pkg::addr_t         link_addr
);

    import ras_pkg::*;

    ////////////////////
    // RV32I opcodes of interest.

    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // x1 (ra) or x5 (t0) act as link registers.
    function automatic logic is_link(input logic [4:0] r);
        return (r == 5'd1) || (r == 5'd5);
    endfunction

    ////////////////////
    // Field extraction.

    logic [6:0] opcode;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [2:0] funct3;

    assign opcode = fetch_instr[6:0];
    assign rd     = fetch_instr[11:7];
    assign funct3 = fetch_instr[14:12];
    assign rs1    = fetch_instr[19:15];

    logic rd_link;  // rd is x1 or x5.
    logic rs1_link; // rs1 is x1 or x5.
    logic is_jal;
    logic is_jalr;
    logic is_branch;

    assign rd_link  = is_link(rd);
    assign rs1_link = is_link(rs1);

    assign is_jal    = (opcode == OPC_JAL);
    assign is_jalr   = (opcode == OPC_JALR) && (funct3 == 3'b000); // Only funct3 0 is legal.
    // funct3 010 and 011 are unused in the branch space.
    assign is_branch = (opcode == OPC_BRANCH) && (funct3[2:1] != 2'b01);

    ////////////////////
    // Classification.

    always_comb begin
        kind       = XFER_NONE; // Plain instruction by default.
        push       = 1'b0;
        pop        = 1'b0;
        checkpoint = 1'b0;
        link_addr  = '0;

        if (fetch_valid) begin
            link_addr = fetch_pc + addr_t'(4); // No compressed encodings.

            if (is_jal) begin
                // A jal without a link register is a plain jump.
                if (rd_link) begin
                    kind = XFER_CALL;
                    push = 1'b1;
                end
            end else if (is_jalr) begin
                checkpoint = 1'b1; // Indirect target can be wrong.
                if (rd_link && rs1_link && (rd != rs1)) begin
                    kind = XFER_CORO; // Swap pops the old top and pushes the new.
                    pop  = 1'b1;
                    push = 1'b1;
                end else if (rd_link) begin
                    kind = XFER_CALL; // Includes rd == rs1 link case.
                    push = 1'b1;
                end else if (rs1_link) begin
                    kind = XFER_RETURN;
                    pop  = 1'b1;
                end
                // An indirect jump through other registers leaves the stack alone.
            end else if (is_branch) begin
                kind       = XFER_BRANCH;
                checkpoint = 1'b1;
            end
        end
    end

endmodule

// File: design/ras_pkg.sv
`include "ras_macros.svh"

package ras_pkg;

    ////////////////////
    // Derived widths.

    // Stack pointer width. A depth of one still needs a single bit.
    localparam int RAS_INDEX_W = (`RAS_DEPTH > 1) ? $clog2(`RAS_DEPTH) : 1;

    // Credit counter must hold 0 up to RAS_MAX_IDS inclusive.
    localparam int CREDIT_W = $clog2(`RAS_MAX_IDS + 1);

    ////////////////////
    // Types.

    typedef logic [`RAS_ADDR_W-1:0] addr_t; // One instruction address.

    typedef logic [RAS_INDEX_W-1:0] ras_index_t; // Return-stack pointer.

    typedef logic [CREDIT_W-1:0] credit_t; // Credits freed or held.

    // Control-transfer class of a fetched instruction.
    // XFER_CORO is a jalr that swaps link registers. It pops, then pushes.
    typedef enum logic [2:0] {
        XFER_NONE   = 3'd0, // Not a stack or branch event.
        XFER_BRANCH = 3'd1, // Conditional branch.
        XFER_CALL   = 3'd2, // jal or jalr that links.
        XFER_RETURN = 3'd3, // jalr through a link register.
        XFER_CORO   = 3'd4  // Coroutine swap.
    } xfer_kind_t;

endpackage

// File: design/ras_macros.svh
`ifndef RAS_MACROS_SVH
`define RAS_MACROS_SVH

////////////////////
// Return-stack sizing.

// Entries in the return stack. Keep it a power of two so the
// pointer wraps for free.
`define RAS_DEPTH 8

////////////////////
// Checkpoint sizing.

// Branches in flight, and also the credits granted at reset.
`define RAS_MAX_IDS 4

////////////////////
// Address width.

`define RAS_ADDR_W 32 // RV32 word address width.

`endif
